// ==== filelist.f ====
+incdir+.
hdc_pkg.sv
axil_write_channel.sv
axil_read_channel.sv
hd_ctrl_regs.sv
item_mem_gen.sv
hdc_ctrl_top.sv
tb_hdc_ctrl.sv

// ==== Makefile ====
SRCS := hdc_pkg.sv axil_write_channel.sv axil_read_channel.sv hd_ctrl_regs.sv \
        item_mem_gen.sv hdc_ctrl_top.sv tb_hdc_ctrl.sv tb_hdc_tasks.svh

.PHONY: all run clean

all: obj_dir/Vtb_hdc_ctrl

# rebuilt only when a source or the file list changes
obj_dir/Vtb_hdc_ctrl: $(SRCS) filelist.f
	verilator --binary --timing --assert --top-module tb_hdc_ctrl -f filelist.f

run: obj_dir/Vtb_hdc_ctrl
	./obj_dir/Vtb_hdc_ctrl > sim.log 2>&1; cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_hdc_tasks.svh ====
`ifndef TB_HDC_TASKS_SVH
`define TB_HDC_TASKS_SVH

// ----------------------------------------------------------------------------
// address map and reference model
// ----------------------------------------------------------------------------

// bits 11:10 region, 9:2 word
function automatic logic [31:0] make_addr(input logic [1:0] region, input logic [7:0] idx);
    return {20'd0, region, idx, 2'b00};
endfunction

// xorshift32 step, 13 left, 17 right, 5 left
function automatic logic [31:0] xorshift_next(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// ----------------------------------------------------------------------------
// AXI-Lite master
// ----------------------------------------------------------------------------

// order 0 together, 1 address first, 2 data first
task automatic send_write(input logic [31:0] addr, input logic [31:0] data, input int order);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(negedge aclk);
    awaddr  = addr;
    wdata   = data;
    awvalid = (order != 2);
    wvalid  = (order != 1);
    while (!(aw_done && w_done)) begin
        // ready settled well before the rising edge
        #1;
        if (awvalid && awready) begin
            aw_done = 1'b1;
        end
        if (wvalid && wready) begin
            w_done = 1'b1;
        end
        @(negedge aclk);
        awvalid = !aw_done;
        wvalid  = !w_done;
    end
endtask

// bready held low for hold cycles once bvalid is up
task automatic take_bresp(input int hold);
    while (bvalid !== 1'b1) begin
        @(negedge aclk);
    end
    if (bresp !== 2'b00) begin
        value_error(32'd0, {30'd0, bresp});
    end
    for (int i = 0; i < hold; i++) begin
        if (bvalid !== 1'b1) begin
            other_error("bvalid dropped before bready");
        end
        if ({awready, wready, arready} !== 3'b000) begin
            other_error("a ready went high while the write response was pending");
        end
        @(negedge aclk);
    end
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
    if (bvalid !== 1'b0) begin
        other_error("bvalid still high after the response was taken");
    end
endtask

task automatic wait_ar_accept();
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
        #1;
        accepted = arready;
        @(negedge aclk);
    end
    arvalid = 1'b0;
endtask

task automatic send_read(input logic [31:0] addr);
    @(negedge aclk);
    araddr  = addr;
    arvalid = 1'b1;
    wait_ar_accept();
endtask

// rready held low for hold cycles, rdata must not move
task automatic take_rdata(input int hold, output logic [31:0] data);
    while (rvalid !== 1'b1) begin
        @(negedge aclk);
    end
    data = rdata;
    if (rresp !== 2'b00) begin
        value_error(32'd0, {30'd0, rresp});
    end
    for (int i = 0; i < hold; i++) begin
        if (rvalid !== 1'b1) begin
            other_error("rvalid dropped before rready");
        end
        if (rdata !== data) begin
            value_error(data, rdata);
        end
        if (arready !== 1'b0) begin
            other_error("arready high while the read response was pending");
        end
        @(negedge aclk);
    end
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
endtask

task automatic write_word(input logic [31:0] addr, input logic [31:0] data, input int order);
    send_write(addr, data, order);
    take_bresp(0);
endtask

task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    send_read(addr);
    take_rdata(0, data);
endtask

// latency follows the count, gen reading 0 marks the end
task automatic wait_gen_clear();
    logic [31:0] mode;
    mode = 32'd1;
    while (mode[0] === 1'b1) begin
        read_word(make_addr(2'd0, 8'd0), mode);
    end
    if (mode !== 32'd0) begin
        value_error(32'd0, mode);
    end
endtask

// ----------------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------------
task automatic reset_values();
    logic [31:0] got;
    start_test("reset_values");
    if ({awready, wready, arready} !== 3'b111) begin
        other_error("a ready is low after reset");
    end
    if ({bvalid, rvalid} !== 2'b00) begin
        other_error("a valid is high after reset");
    end
    for (int i = 0; i < 3; i++) begin
        read_word(make_addr(2'd0, 8'(i)), got);
        if (got !== 32'd0) begin
            value_error(32'd0, got);
        end
    end
    end_test();
endtask

task automatic register_access();
    logic [31:0] v_num;
    logic [31:0] v_rst;
    logic [31:0] got;
    logic [31:0] holes [4];
    start_test("register_access");
    // all three channel orders
    for (int order = 0; order < 3; order++) begin
        v_num = $random(seed);
        v_rst = $random(seed);
        write_word(make_addr(2'd0, 8'd1), v_num, order);
        write_word(make_addr(2'd0, 8'd2), v_rst, order);
        read_word(make_addr(2'd0, 8'd1), got);
        if (got !== (v_num & 32'h3ff)) begin
            value_error(v_num & 32'h3ff, got);
        end
        read_word(make_addr(2'd0, 8'd2), got);
        if (got !== (v_rst & 32'h1)) begin
            value_error(v_rst & 32'h1, got);
        end
    end
    // unmapped word and region 2 dropped
    write_word(make_addr(2'd0, 8'd3), $random(seed), 0);
    write_word(make_addr(2'd2, 8'd1), $random(seed), 0);
    read_word(make_addr(2'd0, 8'd1), got);
    if (got !== (v_num & 32'h3ff)) begin
        value_error(v_num & 32'h3ff, got);
    end
    read_word(make_addr(2'd0, 8'd2), got);
    if (got !== (v_rst & 32'h1)) begin
        value_error(v_rst & 32'h1, got);
    end
    read_word(make_addr(2'd0, 8'd0), got);
    if (got !== 32'd0) begin
        value_error(32'd0, got);
    end
    holes[0] = make_addr(2'd0, 8'd3);
    holes[1] = make_addr(2'd0, 8'd255);
    holes[2] = make_addr(2'd2, 8'd1);
    holes[3] = make_addr(2'd3, 8'd0);
    foreach (holes[i]) begin
        read_word(holes[i], got);
        if (got !== 32'd0) begin
            value_error(32'd0, got);
        end
    end
    end_test();
endtask

task automatic seeded_generation();
    logic [31:0] got;
    start_test("seeded_generation");
    write_word(make_addr(2'd0, 8'd1), 32'd40, 0);
    write_word(make_addr(2'd0, 8'd2), 32'd1, 0);
    write_word(make_addr(2'd0, 8'd0), 32'd1, 0);
    wait_gen_clear();
    model_xs = XS_START;
    for (int i = 0; i < 40; i++) begin
        model_xs = xorshift_next(model_xs);
        read_word(make_addr(2'd1, 8'(i)), got);
        if (got !== model_xs) begin
            value_error(model_xs, got);
        end
    end
    end_test();
endtask

// 300 clipped to 256, sequence picks up after word 40
task automatic continued_generation();
    logic [31:0] got;
    start_test("continued_generation");
    write_word(make_addr(2'd0, 8'd2), 32'd0, 2);
    write_word(make_addr(2'd0, 8'd1), 32'd300, 1);
    write_word(make_addr(2'd0, 8'd0), 32'd1, 0);
    wait_gen_clear();
    read_word(make_addr(2'd0, 8'd1), got);
    if (got !== 32'd300) begin
        value_error(32'd300, got);
    end
    for (int i = 0; i < 256; i++) begin
        model_xs = xorshift_next(model_xs);
        read_word(make_addr(2'd1, 8'(i)), got);
        if (got !== model_xs) begin
            value_error(model_xs, got);
        end
    end
    end_test();
endtask

task automatic back_pressure();
    logic [31:0] v;
    logic [31:0] got;
    int          hold;
    start_test("back_pressure");
    v    = $random(seed);
    hold = 3 + ($unsigned($random(seed)) % 6);
    send_write(make_addr(2'd0, 8'd1), v, 0);
    take_bresp(hold);
    hold = 3 + ($unsigned($random(seed)) % 6);
    send_read(make_addr(2'd0, 8'd1));
    // source register changes while the read response waits
    send_write(make_addr(2'd0, 8'd1), ~v, 0);
    take_bresp(0);
    take_rdata(hold, got);
    if (got !== (v & 32'h3ff)) begin
        value_error(v & 32'h3ff, got);
    end
    read_word(make_addr(2'd0, 8'd1), got);
    if (got !== (~v & 32'h3ff)) begin
        value_error(~v & 32'h3ff, got);
    end
    end_test();
endtask

// AW, W and AR in one cycle, the read sees the new value
task automatic write_priority();
    logic [31:0] v;
    logic [31:0] got;
    start_test("write_priority");
    v = $random(seed);
    @(negedge aclk);
    awaddr  = make_addr(2'd0, 8'd1);
    wdata   = v;
    araddr  = make_addr(2'd0, 8'd1);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    arvalid = 1'b1;
    #1;
    if (arready !== 1'b0) begin
        other_error("read accepted in the same cycle as a write");
    end
    if ({awready, wready} !== 2'b11) begin
        other_error("write not accepted at once");
    end
    @(negedge aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    take_bresp(0);
    // arvalid still up, taken once the write side is quiet
    wait_ar_accept();
    take_rdata(0, got);
    if (got !== (v & 32'h3ff)) begin
        value_error(v & 32'h3ff, got);
    end
    end_test();
endtask

`endif

// ==== tb_hdc_ctrl.sv ====
`timescale 1ns/1ps

module tb_hdc_ctrl;

    // ~300 item reads at about six cycles each, two generations, then margin
    localparam int TIMEOUT_CYCLES = 4000;

    // xorshift32 start value
    localparam logic [31:0] XS_START = 32'd2463534242;

    logic        aclk = 1'b0;
    logic        aresetn;

    // AXI-Lite master side
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic        bready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;

    // stimulus and bookkeeping
    integer      seed = 96481;
    int          cycles = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors_at_start = 0;
    string       test_name = "";

    // model state, carried from one generation to the next
    logic [31:0] model_xs;

    // 4 ns clock
    always #2 aclk = ~aclk;

    hdc_ctrl_top uut (
        .S_AXI_ACLK    (aclk),
        .S_AXI_ARESETN (aresetn),
        .S_AXI_AWADDR  (awaddr),
        .S_AXI_AWVALID (awvalid),
        .S_AXI_AWREADY (awready),
        .S_AXI_WDATA   (wdata),
        .S_AXI_WSTRB   (wstrb),
        .S_AXI_WVALID  (wvalid),
        .S_AXI_WREADY  (wready),
        .S_AXI_BREADY  (bready),
        .S_AXI_BRESP   (bresp),
        .S_AXI_BVALID  (bvalid),
        .S_AXI_ARADDR  (araddr),
        .S_AXI_ARVALID (arvalid),
        .S_AXI_ARREADY (arready),
        .S_AXI_RREADY  (rready),
        .S_AXI_RDATA   (rdata),
        .S_AXI_RRESP   (rresp),
        .S_AXI_RVALID  (rvalid)
    );

    // ------------------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------------------
    task automatic value_error(input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
    endtask

    task automatic other_error(input string msg);
        errors++;
        $display("[ERROR] %s: %s", test_name, msg);
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    // one line per test
    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    `include "tb_hdc_tasks.svh"

    // hang guard
    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = 4'hf;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        model_xs = XS_START;
        aresetn  = 1'b0;

        // reset for three cycles, released on a falling edge
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        reset_values();
        register_access();
        seeded_generation();
        continued_generation();
        back_pressure();
        write_priority();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== hdc_ctrl_top.sv ====
`timescale 1ns/1ps

module hdc_ctrl_top (
    input  logic                        S_AXI_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  logic [hdc_pkg::AXIL_AW-1:0] S_AXI_AWADDR,
    input  logic                        S_AXI_AWVALID,
    output logic                        S_AXI_AWREADY,
    input  logic [hdc_pkg::AXIL_DW-1:0] S_AXI_WDATA,
    input  logic [3:0]                  S_AXI_WSTRB,
    input  logic                        S_AXI_WVALID,
    output logic                        S_AXI_WREADY,
    input  logic                        S_AXI_BREADY,
    output logic [1:0]                  S_AXI_BRESP,
    output logic                        S_AXI_BVALID,
    input  logic [hdc_pkg::AXIL_AW-1:0] S_AXI_ARADDR,
    input  logic                        S_AXI_ARVALID,
    output logic                        S_AXI_ARREADY,
    input  logic                        S_AXI_RREADY,
    output logic [hdc_pkg::AXIL_DW-1:0] S_AXI_RDATA,
    output logic [1:0]                  S_AXI_RRESP,
    output logic                        S_AXI_RVALID
);
    import hdc_pkg::*;

    // WSTRB taken but not used, full-word writes only

    reg_wr_t           wr;
    reg_rd_t           rd;
    logic              wr_quiet;
    hd_ctrl_t          ctrl;
    logic              gen_start;
    logic              gen_done;
    logic [ITEM_W-1:0] item_rdata;

    // ------------------------------------------------------------------------
    // AXI-Lite channels
    // ------------------------------------------------------------------------
    axil_write_channel u_wr (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awaddr        (S_AXI_AWADDR),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bready        (S_AXI_BREADY),
        .bvalid        (S_AXI_BVALID),
        .bresp         (S_AXI_BRESP),
        .wr            (wr),
        .wr_quiet      (wr_quiet)
    );

    axil_read_channel u_rd (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .araddr        (S_AXI_ARADDR),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rready        (S_AXI_RREADY),
        .rvalid        (S_AXI_RVALID),
        .rresp         (S_AXI_RRESP),
        .wr_quiet      (wr_quiet),
        .rd            (rd)
    );

    // ------------------------------------------------------------------------
    // registers and item memory
    // ------------------------------------------------------------------------
    hd_ctrl_regs u_regs (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .wr            (wr),
        .rd            (rd),
        .gen_done      (gen_done),
        .item_rdata    (item_rdata),
        .ctrl          (ctrl),
        .gen_start     (gen_start),
        .rdata         (S_AXI_RDATA)
    );

    item_mem_gen u_items (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .ctrl          (ctrl),
        .gen_start     (gen_start),
        .rd_idx        (rd.idx),
        .gen_done      (gen_done),
        .item_rdata    (item_rdata)
    );

endmodule

// ==== item_mem_gen.sv ====
`timescale 1ns/1ps

module item_mem_gen (
    input  logic                           S_AXI_ACLK,
    input  logic                           S_AXI_ARESETN,
    input  hdc_pkg::hd_ctrl_t              ctrl,
    input  logic                           gen_start,
    input  logic [hdc_pkg::ITEM_IDX_W-1:0] rd_idx,
    output logic                           gen_done,
    output logic [hdc_pkg::ITEM_W-1:0]     item_rdata
);
    import hdc_pkg::*;

    // one xorshift32 step
    function automatic logic [ITEM_W-1:0] xs_step(input logic [ITEM_W-1:0] x);
        logic [ITEM_W-1:0] t;
        t = x ^ (x << XS_SHIFT_A);
        t = t ^ (t >> XS_SHIFT_B);
        t = t ^ (t << XS_SHIFT_C);
        return t;
    endfunction

    // item store
    logic [ITEM_W-1:0] mem [ITEM_DEPTH];

    // generator state
    logic                  busy;
    logic [ITEM_IDX_W-1:0] widx;
    logic [ITEM_IDX_W:0]   cnt_q;
    logic [ITEM_W-1:0]     xs;

    logic [ITEM_IDX_W:0]   clip_num;
    logic [ITEM_W-1:0]     xs_next;

    // counts above the memory size stop at ITEM_DEPTH
    assign clip_num = (ctrl.item_num > ITEM_NUM_W'(ITEM_DEPTH)) ?
                      (ITEM_IDX_W + 1)'(ITEM_DEPTH) : ctrl.item_num[ITEM_IDX_W:0];

    assign xs_next = xs_step(xs);

    // ------------------------------------------------------------------------
    // sequencer, one word per cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            busy     <= 1'b0;
            widx     <= '0;
            cnt_q    <= '0;
            xs       <= '0;
            gen_done <= 1'b0;
        end else begin
            gen_done <= 1'b0;
            if (gen_start && !busy) begin
                // restart from seed, else continue the sequence
                if (ctrl.reset_item) begin
                    xs <= XS_SEED;
                end
                widx     <= '0;
                cnt_q    <= clip_num;
                busy     <= (clip_num != '0);
                // empty run finishes at once
                gen_done <= (clip_num == '0);
            end else if (busy) begin
                xs   <= xs_next;
                widx <= widx + 1'b1;
                if ({1'b0, widx} == cnt_q - 1'b1) begin
                    busy     <= 1'b0;
                    gen_done <= 1'b1;
                end
            end
        end
    end

    // stored word is the state after its step
    always_ff @(posedge S_AXI_ACLK) begin
        if (busy) begin
            mem[widx] <= xs_next;
        end
        item_rdata <= mem[rd_idx];
    end

    a_widx_in_range: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        busy |-> ({1'b0, widx} < cnt_q)
    );

endmodule

// ==== hd_ctrl_regs.sv ====
`timescale 1ns/1ps

module hd_ctrl_regs (
    input  logic                        S_AXI_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  hdc_pkg::reg_wr_t            wr,
    input  hdc_pkg::reg_rd_t            rd,
    input  logic                        gen_done,
    input  logic [hdc_pkg::ITEM_W-1:0]  item_rdata,
    output hdc_pkg::hd_ctrl_t           ctrl,
    output logic                        gen_start,
    output logic [hdc_pkg::AXIL_DW-1:0] rdata
);
    import hdc_pkg::*;

    logic               wr_ctrl;
    logic [AXIL_DW-1:0] rd_word;

    assign wr_ctrl = wr.valid && (wr.region == REGION_CTRL);

    // ------------------------------------------------------------------------
    // mode register writes
    // ------------------------------------------------------------------------
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            ctrl      <= '0;
            gen_start <= 1'b0;
        end else begin
            gen_start <= 1'b0;

            // generation finished, gen clears itself
            if (gen_done) begin
                ctrl.gen <= 1'b0;
            end

            // a write in the same cycle overrides the clear
            if (wr_ctrl) begin
                case (wr.idx)
                    OFS_MODE: begin
                        ctrl.run  <= wr.data[1];
                        ctrl.gen  <= wr.data[0];
                        // rising gen only
                        gen_start <= wr.data[0] && !ctrl.gen;
                    end
                    OFS_ITEM_NUM: begin
                        ctrl.item_num <= wr.data[ITEM_NUM_W-1:0];
                    end
                    OFS_RESET_ITEM: begin
                        ctrl.reset_item <= wr.data[0];
                    end
                    // unmapped words ignored
                    default: ;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // read mux
    // ------------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        if (rd.region == REGION_CTRL) begin
            case (rd.idx)
                OFS_MODE:       rd_word[1:0] = {ctrl.run, ctrl.gen};
                OFS_ITEM_NUM:   rd_word[ITEM_NUM_W-1:0] = ctrl.item_num;
                OFS_RESET_ITEM: rd_word[0] = ctrl.reset_item;
                default:        rd_word = '0;
            endcase
        end else if (rd.region == REGION_ITEM) begin
            // already registered by the item memory
            rd_word = item_rdata;
        end
    end

    // rdata only moves in the fetch cycle, stable during rvalid
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd.valid) begin
            rdata <= rd_word;
        end
    end

    a_gen_fall: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        $fell(ctrl.gen) && $past(S_AXI_ARESETN) |-> $past(gen_done || wr.valid)
    );

endmodule

// ==== axil_read_channel.sv ====
`timescale 1ns/1ps

module axil_read_channel (
    input  logic                        S_AXI_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  logic [hdc_pkg::AXIL_AW-1:0] araddr,
    input  logic                        arvalid,
    output logic                        arready,
    input  logic                        rready,
    output logic                        rvalid,
    output logic [1:0]                  rresp,
    input  logic                        wr_quiet,
    output hdc_pkg::reg_rd_t            rd
);
    import hdc_pkg::*;

    // look gives the item memory its registered read cycle
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_LOOK,
        RS_FETCH,
        RS_RESP
    } rstate_t;

    rstate_t state;

    logic [1:0]            addr_region;
    logic [ITEM_IDX_W-1:0] addr_idx;

    // a write seen in the same cycle wins
    assign arready = (state == RS_IDLE) && wr_quiet;
    assign rvalid  = (state == RS_RESP);
    assign rresp   = RESP_OKAY;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= RS_IDLE;
        end else begin
            case (state)
                RS_IDLE: begin
                    if (arvalid && arready) begin
                        state <= RS_LOOK;
                    end
                end
                RS_LOOK:  state <= RS_FETCH;
                RS_FETCH: state <= RS_RESP;
                default: begin
                    if (rready) begin
                        state <= RS_IDLE;
                    end
                end
            endcase
        end
    end

    // held from acceptance to the end of the response
    always_ff @(posedge S_AXI_ACLK) begin
        if (arvalid && arready) begin
            addr_region <= araddr[11:10];
            addr_idx    <= araddr[9:2];
        end
    end

    assign rd = '{valid: (state == RS_FETCH), region: addr_region, idx: addr_idx};

    a_no_ar_in_resp: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(arready && rvalid)
    );

endmodule

// ==== axil_write_channel.sv ====
`timescale 1ns/1ps

module axil_write_channel (
    input  logic                        S_AXI_ACLK,
    input  logic                        S_AXI_ARESETN,
    input  logic [hdc_pkg::AXIL_AW-1:0] awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [hdc_pkg::AXIL_DW-1:0] wdata,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic                        bready,
    output logic                        bvalid,
    output logic [1:0]                  bresp,
    output hdc_pkg::reg_wr_t            wr,
    output logic                        wr_quiet
);
    import hdc_pkg::*;

    // idle, address only, data only, both held (response)
    typedef enum logic [1:0] {
        WS_IDLE,
        WS_ADDR,
        WS_DATA,
        WS_RESP
    } wstate_t;

    wstate_t state;

    // captured payload
    logic [1:0]            addr_region;
    logic [ITEM_IDX_W-1:0] addr_idx;
    logic [AXIL_DW-1:0]    data_q;

    // high in the first response cycle only
    logic first_resp;

    logic aw_take;
    logic w_take;
    logic addr_ok;
    logic data_ok;

    // ------------------------------------------------------------------------
    // handshakes
    // ------------------------------------------------------------------------
    assign awready = (state == WS_IDLE) || (state == WS_DATA);
    assign wready  = (state == WS_IDLE) || (state == WS_ADDR);
    assign bvalid  = (state == WS_RESP);
    assign bresp   = RESP_OKAY;

    assign aw_take = awready && awvalid;
    assign w_take  = wready && wvalid;

    // address / data on hand after this edge
    assign addr_ok = aw_take || (state == WS_ADDR);
    assign data_ok = w_take || (state == WS_DATA);

    // nothing pending and nothing on the way, lets a read start
    assign wr_quiet = (state == WS_IDLE) && !awvalid && !wvalid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state      <= WS_IDLE;
            first_resp <= 1'b0;
        end else begin
            first_resp <= 1'b0;
            if (state == WS_RESP) begin
                // hold the response until the master takes it
                if (bready) begin
                    state <= WS_IDLE;
                end
            end else if (addr_ok && data_ok) begin
                state      <= WS_RESP;
                first_resp <= 1'b1;
            end else if (addr_ok) begin
                state <= WS_ADDR;
            end else if (data_ok) begin
                state <= WS_DATA;
            end
        end
    end

    // address bits 11:10 region, 9:2 word
    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_take) begin
            addr_region <= awaddr[11:10];
            addr_idx    <= awaddr[9:2];
        end
        if (w_take) begin
            data_q <= wdata;
        end
    end

    assign wr = '{valid: first_resp, region: addr_region, idx: addr_idx, data: data_q};

    // one strobe per write, in the cycle bvalid rises
    a_wr_first_resp: assert property (
        @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        wr.valid |-> bvalid && !$past(bvalid)
    );

endmodule

// ==== hdc_pkg.sv ====
package hdc_pkg;

    // ------------------------------------------------------------------------
    // bus and item widths
    // ------------------------------------------------------------------------
    localparam int AXIL_AW    = 32;
    localparam int AXIL_DW    = 32;

    // one 32-bit word per item hypervector
    localparam int ITEM_W     = 32;
    localparam int ITEM_DEPTH = 256;
    localparam int ITEM_IDX_W = $clog2(ITEM_DEPTH);

    // count register is wider than the memory, clipped on use
    localparam int ITEM_NUM_W = 10;

    // ------------------------------------------------------------------------
    // address map, bits 11:10 pick the region, bits 9:2 the word
    // ------------------------------------------------------------------------
    localparam logic [1:0] REGION_CTRL = 2'd0;
    localparam logic [1:0] REGION_ITEM = 2'd1;

    localparam logic [ITEM_IDX_W-1:0] OFS_MODE       = 8'd0;
    localparam logic [ITEM_IDX_W-1:0] OFS_ITEM_NUM   = 8'd1;
    localparam logic [ITEM_IDX_W-1:0] OFS_RESET_ITEM = 8'd2;

    // xorshift32 seed and shifts (left, right, left)
    localparam logic [ITEM_W-1:0] XS_SEED = 32'd2463534242;
    localparam int XS_SHIFT_A = 13;
    localparam int XS_SHIFT_B = 17;
    localparam int XS_SHIFT_C = 5;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ------------------------------------------------------------------------
    // internal strobes between the channels and the register block
    // ------------------------------------------------------------------------

    // one register write, valid pulses once per transaction
    typedef struct packed {
        logic                  valid;
        logic [1:0]            region;
        logic [ITEM_IDX_W-1:0] idx;
        logic [AXIL_DW-1:0]    data;
    } reg_wr_t;

    // one register read, region and idx held through the transaction
    typedef struct packed {
        logic                  valid;
        logic [1:0]            region;
        logic [ITEM_IDX_W-1:0] idx;
    } reg_rd_t;

    // mode registers as seen by the generator
    typedef struct packed {
        logic                  run;
        logic                  gen;
        logic                  reset_item;
        logic [ITEM_NUM_W-1:0] item_num;
    } hd_ctrl_t;

endpackage
